// ==== rtl/core_pkg.sv ====
package core_pkg;

  import isa_pkg::*;

  localparam int NUM_SLOTS = 4;
  localparam int SLOT_BITS = $clog2(NUM_SLOTS);

  // Functional-unit class served by each reservation-station slot
  localparam fu_class_t SLOT_CLASS [NUM_SLOTS] = '{
    ALU,  // Slot 0
    ALU,  // Slot 1
    MUL,  // Slot 2
    MEM   // Slot 3
  };

  // Free-slot search starts at the lowest ALU slot and runs upward
  localparam int ALU_SLOT_FIRST = 0;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

  localparam int REG_BITS      = 3;
  localparam int NUM_ARCH_REGS = 8;

  typedef enum logic [3:0] {
    ALU_REG   = 4'd0,
    ALU_IMM   = 4'd1,
    MUL_REG   = 4'd2,
    LOAD_IMM  = 4'd3,
    STORE_REG = 4'd4
  } opcode_t;

  typedef enum logic [1:0] {
    ALU = 2'd0,
    MUL = 2'd1,
    MEM = 2'd2
  } fu_class_t;

  typedef struct packed {
    opcode_t             opcode;
    logic [REG_BITS-1:0] dest;
    logic [REG_BITS-1:0] src1;
    logic [REG_BITS-1:0] src2;
    logic [2:0]          funct;  // Minor operation select
  } op_reg_t;

  typedef struct packed {
    opcode_t             opcode;
    logic [REG_BITS-1:0] dest;
    logic [REG_BITS-1:0] src1;
    logic [5:0]          imm;    // Overlays src2 and funct
  } op_imm_t;

  typedef union packed {
    op_reg_t rform;
    op_imm_t iform;
  } op_word_t;

endpackage

// ==== rtl/rename_stage.sv ====
`timescale 1ns/100ps

module rename_stage import isa_pkg::*; #(
  parameter  int ROB_DEPTH = 16,
  localparam int TAG_BITS  = $clog2(ROB_DEPTH)
) (
  input  logic                clock,
  input  logic                reset,
  input  op_word_t            dispatch_op,
  input  logic                dispatch_accept,
  input  logic [TAG_BITS-1:0] alloc_tag,
  input  logic                cdb_valid,
  input  logic [TAG_BITS-1:0] cdb_tag,
  input  logic                rollback_valid,
  input  logic [TAG_BITS-1:0] rollback_tag,
  input  logic [TAG_BITS-1:0] squash_window,
  output fu_class_t           op_class,
  output logic [TAG_BITS-1:0] src1_tag,
  output logic                src1_ready,
  output logic [TAG_BITS-1:0] src2_tag,
  output logic                src2_ready
);

  logic [NUM_ARCH_REGS-1:0]               pending;   // Register awaits a producer
  logic [NUM_ARCH_REGS-1:0][TAG_BITS-1:0] prod_tag;
  logic [NUM_ARCH_REGS-1:0][TAG_BITS-1:0] prod_age;
  opcode_t                                opcode;
  logic                                   is_imm;
  logic                                   writes_dest;
  logic [REG_BITS-1:0]                    src1_reg;
  logic [REG_BITS-1:0]                    src2_reg;
  logic [REG_BITS-1:0]                    dest_reg;

  assign opcode      = dispatch_op.rform.opcode;
  assign is_imm      = (opcode == ALU_IMM) || (opcode == LOAD_IMM);
  assign writes_dest = (opcode != STORE_REG);
  assign src1_reg    = dispatch_op.rform.src1;
  assign src2_reg    = dispatch_op.rform.src2;  // Only meaningful in register form
  assign dest_reg    = dispatch_op.rform.dest;

  always_comb begin
    case (opcode)
      MUL_REG:             op_class = MUL;
      LOAD_IMM, STORE_REG: op_class = MEM;
      default:             op_class = ALU;
    endcase
  end

  // Map lookup with same-cycle CDB forwarding
  assign src1_tag   = prod_tag[src1_reg];
  assign src1_ready = !pending[src1_reg] || (cdb_valid && cdb_tag == prod_tag[src1_reg]);
  assign src2_tag   = is_imm ? '0 : prod_tag[src2_reg];
  assign src2_ready = is_imm || !pending[src2_reg] ||
                      (cdb_valid && cdb_tag == prod_tag[src2_reg]);

  always_comb begin
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
      prod_age[r] = prod_tag[r] - rollback_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else begin
      for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        if (cdb_valid && prod_tag[r] == cdb_tag) begin
          pending[r] <= 1'b0;
        end
        if (rollback_valid && prod_age[r] < squash_window) begin
          pending[r] <= 1'b0;  // Back to architectural value
        end
      end
      if (dispatch_accept && writes_dest) begin
        pending[dest_reg] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_accept && writes_dest) begin
      prod_tag[dest_reg] <= alloc_tag;
    end
  end

endmodule

// ==== rtl/rob_tag_counter.sv ====
`timescale 1ns/100ps

module rob_tag_counter #(
  parameter  int ROB_DEPTH = 16,
  localparam int TAG_BITS  = $clog2(ROB_DEPTH)
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                advance,
  input  logic                rollback_valid,
  input  logic [TAG_BITS-1:0] rollback_tag,
  output logic [TAG_BITS-1:0] next_tag,
  output logic [TAG_BITS-1:0] squash_window
);

  logic [TAG_BITS-1:0] tag_inc;

  // ROB_DEPTH is a power of two so tag arithmetic wraps on its own
  assign tag_inc = next_tag + 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= '0;
    end else if (rollback_valid) begin
      next_tag <= rollback_tag;  // Rewind to oldest squashed tag
    end else if (advance) begin
      next_tag <= tag_inc;
    end
  end

  // Number of in-flight tags at or after rollback_tag
  assign squash_window = next_tag - rollback_tag;

endmodule

// ==== rtl/rollback_fsm.sv ====
`timescale 1ns/100ps

module rollback_fsm #(
  parameter int DRAIN_CYCLES = 3
) (
  input  logic clock,
  input  logic reset,
  input  logic rollback_valid,
  output logic dispatch_open
);

  localparam int CNT_BITS = (DRAIN_CYCLES > 1) ? $clog2(DRAIN_CYCLES + 1) : 1;

  localparam logic [1:0] IDLE   = 2'd0;
  localparam logic [1:0] SQUASH = 2'd1;
  localparam logic [1:0] DRAIN  = 2'd2;

  logic [1:0]          state;
  logic [1:0]          next_state;
  logic [CNT_BITS-1:0] drain_count;

  always_comb begin
    next_state = state;
    if (rollback_valid) begin
      next_state = SQUASH;  // Also restarts a drain in progress
    end else begin
      case (state)
        SQUASH: next_state = (DRAIN_CYCLES == 0) ? IDLE : DRAIN;
        DRAIN: begin
          if (drain_count == CNT_BITS'(1)) begin
            next_state = IDLE;
          end
        end
        default: next_state = IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= IDLE;
      drain_count <= '0;
    end else begin
      state <= next_state;
      if (state != DRAIN && next_state == DRAIN) begin
        drain_count <= CNT_BITS'(DRAIN_CYCLES);
      end else if (state == DRAIN) begin
        drain_count <= drain_count - 1'b1;
      end
    end
  end

  // Closed in the strobe cycle too, so no younger op slips past the squash
  assign dispatch_open = (state == IDLE) && !rollback_valid;

endmodule

// ==== rtl/rs_entries.sv ====
`timescale 1ns/100ps

module rs_entries import isa_pkg::*, core_pkg::*; #(
  parameter  int ROB_DEPTH = 16,
  localparam int TAG_BITS  = $clog2(ROB_DEPTH)
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               dispatch_valid,
  input  logic                               dispatch_open,
  input  op_word_t                           dispatch_op,
  input  fu_class_t                          op_class,
  input  logic [TAG_BITS-1:0]                alloc_tag,
  input  logic [TAG_BITS-1:0]                src1_tag,
  input  logic                               src1_ready,
  input  logic [TAG_BITS-1:0]                src2_tag,
  input  logic                               src2_ready,
  input  logic                               cdb_valid,
  input  logic [TAG_BITS-1:0]                cdb_tag,
  input  logic                               rollback_valid,
  input  logic [TAG_BITS-1:0]                rollback_tag,
  input  logic [TAG_BITS-1:0]                squash_window,
  output logic                               dispatch_accept,
  output logic                               dispatch_reject,
  output logic [NUM_SLOTS-1:0]               issue_valid,
  output logic [NUM_SLOTS-1:0][TAG_BITS-1:0] issue_tag,
  output op_word_t [NUM_SLOTS-1:0]           issue_op,
  output logic [NUM_SLOTS-1:0]               busy_mask
);

  logic [NUM_SLOTS-1:0]               busy;
  logic [NUM_SLOTS-1:0][TAG_BITS-1:0] slot_tag;
  op_word_t [NUM_SLOTS-1:0]           slot_op;
  logic [NUM_SLOTS-1:0][TAG_BITS-1:0] s1_tag;
  logic [NUM_SLOTS-1:0]               s1_ready;
  logic [NUM_SLOTS-1:0][TAG_BITS-1:0] s2_tag;
  logic [NUM_SLOTS-1:0]               s2_ready;
  logic [NUM_SLOTS-1:0][TAG_BITS-1:0] slot_age;  // Distance from rollback_tag
  logic [NUM_SLOTS-1:0]               s1_wake;
  logic [NUM_SLOTS-1:0]               s2_wake;
  logic [NUM_SLOTS-1:0]               squash;
  logic                               fill_hit;
  logic [SLOT_BITS-1:0]               fill_idx;

  // Lowest free slot of the requested class
  always_comb begin
    fill_hit = 1'b0;
    fill_idx = '0;
    for (int s = ALU_SLOT_FIRST; s < NUM_SLOTS; s++) begin
      if (!fill_hit && !busy[s] && SLOT_CLASS[s] == op_class) begin
        fill_hit = 1'b1;
        fill_idx = SLOT_BITS'(s);
      end
    end
  end

  assign dispatch_accept = dispatch_valid && dispatch_open && fill_hit;
  assign dispatch_reject = dispatch_valid && !(dispatch_open && fill_hit);

  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      s1_wake[s]     = cdb_valid && !s1_ready[s] && s1_tag[s] == cdb_tag;
      s2_wake[s]     = cdb_valid && !s2_ready[s] && s2_tag[s] == cdb_tag;
      slot_age[s]    = slot_tag[s] - rollback_tag;
      squash[s]      = rollback_valid && busy[s] && slot_age[s] < squash_window;
      // A squash in the same cycle wins over issue
      issue_valid[s] = busy[s] && s1_ready[s] && s2_ready[s] && !squash[s];
    end
  end

  assign issue_tag = slot_tag;
  assign issue_op  = slot_op;
  assign busy_mask = busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        if (issue_valid[s] || squash[s]) begin
          busy[s] <= 1'b0;
        end
      end
      if (dispatch_accept) begin
        busy[fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (s1_wake[s]) begin
        s1_ready[s] <= 1'b1;
      end
      if (s2_wake[s]) begin
        s2_ready[s] <= 1'b1;
      end
    end
    if (dispatch_accept) begin
      slot_tag[fill_idx] <= alloc_tag;
      slot_op[fill_idx]  <= dispatch_op;
      s1_tag[fill_idx]   <= src1_tag;
      s1_ready[fill_idx] <= src1_ready;  // Already includes CDB forwarding
      s2_tag[fill_idx]   <= src2_tag;
      s2_ready[fill_idx] <= src2_ready;
    end
  end

endmodule

// ==== rtl/rs_subsystem.sv ====
`timescale 1ns/100ps

module rs_subsystem import isa_pkg::*, core_pkg::*; #(
  parameter  int ROB_DEPTH    = 16,
  parameter  int DRAIN_CYCLES = 3,
  localparam int TAG_BITS     = $clog2(ROB_DEPTH)
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               dispatch_valid,
  input  op_word_t                           dispatch_op,
  input  logic                               cdb_valid,
  input  logic [TAG_BITS-1:0]                cdb_tag,
  input  logic                               rollback_valid,
  input  logic [TAG_BITS-1:0]                rollback_tag,
  output logic                               dispatch_accept,
  output logic                               dispatch_reject,
  output logic [TAG_BITS-1:0]                dispatch_tag,
  output logic [NUM_SLOTS-1:0]               issue_valid,
  output logic [NUM_SLOTS-1:0][TAG_BITS-1:0] issue_tag,
  output op_word_t [NUM_SLOTS-1:0]           issue_op,
  output logic [NUM_SLOTS-1:0]               busy_mask
);

  logic [TAG_BITS-1:0] squash_window;
  logic                dispatch_open;
  fu_class_t           op_class;
  logic [TAG_BITS-1:0] src1_tag;
  logic                src1_ready;
  logic [TAG_BITS-1:0] src2_tag;
  logic                src2_ready;

  rob_tag_counter #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_tag_counter (
    .clock          (clock),
    .reset          (reset),
    .advance        (dispatch_accept),
    .rollback_valid (rollback_valid),
    .rollback_tag   (rollback_tag),
    .next_tag       (dispatch_tag),   // Tag offered to the current dispatch
    .squash_window  (squash_window)
  );

  rollback_fsm #(
    .DRAIN_CYCLES (DRAIN_CYCLES)
  ) u_rollback_fsm (
    .clock          (clock),
    .reset          (reset),
    .rollback_valid (rollback_valid),
    .dispatch_open  (dispatch_open)
  );

  rename_stage #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rename (
    .clock           (clock),
    .reset           (reset),
    .dispatch_op     (dispatch_op),
    .dispatch_accept (dispatch_accept),
    .alloc_tag       (dispatch_tag),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .rollback_valid  (rollback_valid),
    .rollback_tag    (rollback_tag),
    .squash_window   (squash_window),
    .op_class        (op_class),
    .src1_tag        (src1_tag),
    .src1_ready      (src1_ready),
    .src2_tag        (src2_tag),
    .src2_ready      (src2_ready)
  );

  rs_entries #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rs (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_open   (dispatch_open),
    .dispatch_op     (dispatch_op),
    .op_class        (op_class),
    .alloc_tag       (dispatch_tag),
    .src1_tag        (src1_tag),
    .src1_ready      (src1_ready),
    .src2_tag        (src2_tag),
    .src2_ready      (src2_ready),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .rollback_valid  (rollback_valid),
    .rollback_tag    (rollback_tag),
    .squash_window   (squash_window),
    .dispatch_accept (dispatch_accept),
    .dispatch_reject (dispatch_reject),
    .issue_valid     (issue_valid),
    .issue_tag       (issue_tag),
    .issue_op        (issue_op),
    .busy_mask       (busy_mask)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reservation-station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module rs_subsystem_tb -o rs_sim

sim_output=$(./obj_dir/rs_sim 2>&1) || true
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

// ==== sim/rs_patterns.txt ====
# dv op cdb_valid cdb_tag rb_valid rb_tag acc rej tag issue issue_tags(slot3..slot0), hex
# One line per cycle; tag is checked on accept only, issue tags where the issue bit is set
# Independent ops fill their class slots and issue next cycle
1 0200 0 0 0 0 1 0 0 0 0000
1 2400 0 0 0 0 1 0 1 1 0000
1 362A 0 0 0 0 1 0 2 4 0100
0 0000 0 0 0 0 0 0 0 8 2000
# Dependent op waits for its producer on the CDB
1 0840 0 0 0 0 1 0 3 0 0000
0 0000 0 0 0 0 0 0 0 0 0000
0 0000 1 0 0 0 0 0 0 0 0000
0 0000 0 0 0 0 0 0 0 1 0003
1 2A80 1 1 0 0 1 0 4 0 0000
0 0000 0 0 0 0 0 0 0 4 0400
# Both ALU slots busy, third ALU op rejected without using a tag
1 0CC0 0 0 0 0 1 0 5 0 0000
1 1F18 0 0 0 0 1 0 6 0 0000
1 0200 0 0 0 0 0 1 0 0 0000
0 0000 1 3 0 0 0 0 0 0 0000
0 0000 0 0 0 0 0 0 0 2 0060
1 0200 0 0 0 0 1 0 7 0 0000
0 0000 0 0 0 0 0 0 0 2 0070
0 0000 1 2 0 0 0 0 0 0 0000
0 0000 0 0 0 0 0 0 0 1 0005
# Immediate form ignores src2 field, store leaves its dest unrenamed
1 3428 0 0 0 0 1 0 8 0 0000
0 0000 0 0 0 0 0 0 0 8 8000
1 4600 0 0 0 0 1 0 9 0 0000
1 08C0 0 0 0 0 1 0 A 8 9000
0 0000 0 0 0 0 0 0 0 1 000A
# Rollback to tag C squashes two waiting slots, then drain
1 0D40 0 0 0 0 1 0 B 0 0000
1 2E40 0 0 0 0 1 0 C 0 0000
1 0340 0 0 0 0 1 0 D 0 0000
1 0200 0 0 1 C 0 1 0 0 0000
1 0200 0 0 0 0 0 1 0 0 0000
1 0200 0 0 0 0 0 1 0 0 0000
1 0200 0 0 0 0 0 1 0 0 0000
1 0200 0 0 0 0 0 1 0 0 0000
1 0478 0 0 0 0 1 0 C 0 0000
0 0000 0 0 0 0 0 0 0 2 00C0
0 0000 1 4 0 0 0 0 0 0 0000
0 0000 0 0 0 0 0 0 0 1 000B
# Ready slot squashed in the same cycle does not issue
1 0600 0 0 0 0 1 0 D 0 0000
0 0000 0 0 1 D 0 0 0 0 0000
1 0600 0 0 0 0 0 1 0 0 0000
1 0600 0 0 0 0 0 1 0 0 0000
1 0600 0 0 0 0 0 1 0 0 0000
1 0600 0 0 0 0 0 1 0 0 0000
1 28C0 0 0 0 0 1 0 D 0 0000
0 0000 0 0 0 0 0 0 0 4 0D00

// ==== sim/rs_subsystem_chk.sv ====
`timescale 1ns/100ps

module rs_subsystem_chk import core_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic                 dispatch_accept,
  input logic                 dispatch_reject,
  input logic                 rollback_valid,
  input logic [NUM_SLOTS-1:0] issue_valid,
  input logic [NUM_SLOTS-1:0] busy_mask
);

  accept_reject_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(dispatch_accept && dispatch_reject)
  ) else $error("dispatch_accept and dispatch_reject are high together");

  // Only occupied slots may issue
  issue_from_busy_slot: assert property (
    @(posedge clock) disable iff (reset) (issue_valid & ~busy_mask) == '0
  ) else $error("issue_valid is high on a slot that is not busy");

  no_accept_after_rollback: assert property (
    @(posedge clock) disable iff (reset) rollback_valid |=> !dispatch_accept
  ) else $error("dispatch accepted in the cycle after a rollback");

endmodule

bind rs_subsystem rs_subsystem_chk u_chk (
  .clock           (clock),
  .reset           (reset),
  .dispatch_accept (dispatch_accept),
  .dispatch_reject (dispatch_reject),
  .rollback_valid  (rollback_valid),
  .issue_valid     (issue_valid),
  .busy_mask       (busy_mask)
);

// ==== sim/rs_subsystem_tb.sv ====
`timescale 1ns/100ps

module rs_subsystem_tb
  import isa_pkg::*, core_pkg::*;
();

  localparam int    ROB_DEPTH    = 16;
  localparam int    DRAIN_CYCLES = 3;
  localparam int    TAG_BITS     = $clog2(ROB_DEPTH);
  localparam int    MAX_STEPS    = 200;  // Upper bound on pattern file lines
  localparam string PATTERN_FILE = "sim/rs_patterns.txt";

  logic                               clock;
  logic                               reset;
  logic                               dispatch_valid;
  op_word_t                           dispatch_op;
  logic                               cdb_valid;
  logic [TAG_BITS-1:0]                cdb_tag;
  logic                               rollback_valid;
  logic [TAG_BITS-1:0]                rollback_tag;
  logic                               dispatch_accept;
  logic                               dispatch_reject;
  logic [TAG_BITS-1:0]                dispatch_tag;
  logic [NUM_SLOTS-1:0]               issue_valid;
  logic [NUM_SLOTS-1:0][TAG_BITS-1:0] issue_tag;
  op_word_t [NUM_SLOTS-1:0]           issue_op;
  logic [NUM_SLOTS-1:0]               busy_mask;

  int          pattern_num;                  // Data lines applied so far
  logic [15:0] dispatched_op [ROB_DEPTH];   // Last accepted op word per tag

  rs_subsystem #(
    .ROB_DEPTH    (ROB_DEPTH),
    .DRAIN_CYCLES (DRAIN_CYCLES)
  ) uut (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_op     (dispatch_op),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .rollback_valid  (rollback_valid),
    .rollback_tag    (rollback_tag),
    .dispatch_accept (dispatch_accept),
    .dispatch_reject (dispatch_reject),
    .dispatch_tag    (dispatch_tag),
    .issue_valid     (issue_valid),
    .issue_tag       (issue_tag),
    .issue_op        (issue_op),
    .busy_mask       (busy_mask)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("[FAIL] time %0d ns, pattern %0d: %s is %0h, expected %0h",
             $time, pattern_num, field, got, want);
    stop_with_failure();
  endtask

  task automatic check_outputs(
    input logic                          exp_accept,
    input logic                          exp_reject,
    input logic [TAG_BITS-1:0]           exp_tag,
    input logic [NUM_SLOTS-1:0]          exp_issue,
    input logic [NUM_SLOTS*TAG_BITS-1:0] exp_issue_tags
  );
    logic [TAG_BITS-1:0] want_tag;

    assert (dispatch_accept === exp_accept) else
      report_mismatch("dispatch_accept", 32'(dispatch_accept), 32'(exp_accept));
    assert (dispatch_reject === exp_reject) else
      report_mismatch("dispatch_reject", 32'(dispatch_reject), 32'(exp_reject));
    if (exp_accept) begin
      assert (dispatch_tag === exp_tag) else
        report_mismatch("dispatch_tag", 32'(dispatch_tag), 32'(exp_tag));
    end
    assert (issue_valid === exp_issue) else
      report_mismatch("issue_valid", 32'(issue_valid), 32'(exp_issue));
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (exp_issue[s]) begin  // Idle slots carry stale tags
        want_tag = exp_issue_tags[s*TAG_BITS +: TAG_BITS];
        assert (issue_tag[s] === want_tag) else
          report_mismatch($sformatf("issue_tag[%0d]", s), 32'(issue_tag[s]),
                          32'(want_tag));
        assert (issue_op[s] === dispatched_op[want_tag]) else
          report_mismatch($sformatf("issue_op[%0d]", s), 32'(issue_op[s]),
                          32'(dispatched_op[want_tag]));
      end
    end
  endtask

  initial begin
    int                          fd;
    int                          steps;
    int                          got_chars;
    int                          fields;
    string                       line;
    logic                        p_dv;
    logic [15:0]                 p_op;
    logic                        p_cv;
    logic [TAG_BITS-1:0]         p_ctag;
    logic                        p_rv;
    logic [TAG_BITS-1:0]         p_rtag;
    logic                        e_acc;
    logic                        e_rej;
    logic [TAG_BITS-1:0]         e_tag;
    logic [NUM_SLOTS-1:0]        e_issue;
    logic [NUM_SLOTS*TAG_BITS-1:0] e_itags;

    dispatch_valid = 1'b0;
    dispatch_op    = '0;
    cdb_valid      = 1'b0;
    cdb_tag        = '0;
    rollback_valid = 1'b0;
    rollback_tag   = '0;
    reset          = 1'b1;
    pattern_num    = 0;
    steps          = 0;

    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PATTERN_FILE);
      stop_with_failure();
    end

    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_outputs(1'b0, 1'b0, '0, '0, '0);  // Quiet outputs straight after reset
    assert (busy_mask === '0) else
      report_mismatch("busy_mask", 32'(busy_mask), 32'h0);

    while (!$feof(fd)) begin
      steps++;
      if (steps > MAX_STEPS) begin
        $display("Timeout: pattern file not exhausted after %0d lines", MAX_STEPS);
        stop_with_failure();
      end
      line      = "";
      got_chars = $fgets(line, fd);
      if (got_chars > 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", p_dv, p_op, p_cv,
                         p_ctag, p_rv, p_rtag, e_acc, e_rej, e_tag, e_issue, e_itags);
        if (fields > 0 && fields != 11) begin
          $display("Pattern file line %0d has %0d fields instead of 11", steps, fields);
          stop_with_failure();
        end
        if (fields == 11) begin
          pattern_num++;
          if (e_acc) begin
            dispatched_op[e_tag] = p_op;
          end
          @(posedge clock);
          dispatch_valid <= p_dv;
          dispatch_op    <= p_op;
          cdb_valid      <= p_cv;
          cdb_tag        <= p_ctag;
          rollback_valid <= p_rv;
          rollback_tag   <= p_rtag;
          @(negedge clock);  // Outputs settled, next edge still ahead
          check_outputs(e_acc, e_rej, e_tag, e_issue, e_itags);
        end
      end
    end
    $fclose(fd);

    @(posedge clock);  // Last issued slot retires here
    dispatch_valid <= 1'b0;
    cdb_valid      <= 1'b0;
    rollback_valid <= 1'b0;
    @(negedge clock);
    assert (busy_mask === '0) else  // Every patterned op issued or was squashed
      report_mismatch("busy_mask", 32'(busy_mask), 32'h0);

    if (pattern_num == 0) begin
      $display("No usable pattern lines were found in %s", PATTERN_FILE);
      stop_with_failure();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/rob_tag_counter.sv
rtl/rollback_fsm.sv
rtl/rename_stage.sv
rtl/rs_entries.sv
rtl/rs_subsystem.sv
sim/rs_subsystem_chk.sv
sim/rs_subsystem_tb.sv
